// ==== bench/cache_tb_tasks.svh ====
// drive the refill strobe for the coming edge and update the model to match
task automatic drive_refill(input logic [31:0] addr, input logic [cache_pkg::line_width-1:0] line);
   cache_pkg::cache_addr_u a;
   logic [cache_pkg::way_width-1:0] victim;
   a.raw        = addr;
   victim       = model_ptr[a.fields.index];
   refill_valid = 1'b1;
   refill_addr  = addr;
   refill_line  = line;
   model_tag[a.fields.index][victim]   = a.fields.tag;
   model_valid[a.fields.index][victim] = 1'b1;
   model_line[a.fields.index][victim]  = line;
   model_ptr[a.fields.index]           = victim + 1'b1;  // wraps after way 3
   known_addrs.push_back(addr);
endtask

task automatic do_refill(input logic [31:0] addr, input logic [cache_pkg::line_width-1:0] line);
   drive_refill(addr, line);
   @(posedge clk);
   #1;
   refill_valid = 1'b0;
endtask

// one read that waits for resp_valid and checks it against the model
task automatic read_and_check(input logic [31:0] addr, input string name);
   logic                            exp_hit;
   logic [cache_pkg::way_width-1:0] exp_way;
   logic [31:0]                     exp_data;
   int                              cycles;
   predict(addr, exp_hit, exp_way, exp_data);
   req_valid = 1'b1;
   req_addr  = addr;
   @(posedge clk);
   #1;
   req_valid    = 1'b0;
   refill_valid = 1'b0;  // ends a refill driven in the same cycle
   cycles       = 1;
   while (!resp_valid) begin
      if (cycles >= resp_timeout) begin
         abort_run($sformatf("no response to the read in %s after %0d cycles", name, cycles));
      end
      @(posedge clk);
      #1;
      cycles++;
   end
   check_value(name, "latency", 32'd2, cycles);
   check_value(name, "resp_hit", exp_hit, resp_hit);
   check_value(name, "resp_way", exp_way, resp_way);
   check_value(name, "resp_data", exp_data, resp_data);
endtask

task automatic cold_miss_reads();
   for (int i = 0; i < 6; i++) begin
      read_and_check(rand_addr(), "cold_miss");  // model is empty so all miss with zero data
   end
endtask

task automatic refill_then_hit();
   cache_pkg::cache_addr_u a;
   a.raw = rand_addr();
   do_refill(a.raw, rand_line());
   for (int ws = 0; ws < 4; ws++) begin
      a.fields.word_sel = ws[cache_pkg::word_sel_width-1:0];
      read_and_check(a.raw, "refill_hit");
   end
endtask

// five tags into one set where the fifth evicts the first
task automatic replacement_order();
   cache_pkg::cache_addr_u          a;
   logic [cache_pkg::way_width-1:0] start;
   a.raw        = rand_addr();
   a.fields.index = 8'h5c;
   start        = model_ptr[a.fields.index];
   for (int i = 0; i < 5; i++) begin
      a.fields.tag = 20'hab000 + i[cache_pkg::tag_width-1:0];
      do_refill(a.raw, rand_line());
   end
   for (int i = 0; i < 5; i++) begin
      a.fields.tag      = 20'hab000 + i[cache_pkg::tag_width-1:0];
      a.fields.word_sel = i[cache_pkg::word_sel_width-1:0];
      read_and_check(a.raw, "replacement");
      check_value("replacement", "hit by order", (i != 0), resp_hit);
      if (i != 0) begin
         check_value("replacement", "way by order", (start + i) % 4, resp_way);
      end
   end
endtask

task automatic same_cycle_bypass();
   cache_pkg::cache_addr_u a;
   a.raw = rand_addr();
   a.fields.word_sel = 2'd3;
   drive_refill(a.raw, rand_line());
   read_and_check(a.raw, "bypass");  // issued in the refill cycle
   read_and_check(a.raw, "bypass_after");
endtask

// back to back reads mixing refilled and random addresses
task automatic back_to_back_reads();
   cache_pkg::cache_addr_u a;
   logic [31:0]            addrs [$];
   logic [34:0]            exp_q [$];  // {hit, way, data}
   logic                   hit;
   logic [1:0]             way;
   logic [31:0]            data;
   logic [34:0]            exp;
   int                     issued;
   int                     cycles;
   bit                     started;
   for (int i = 0; i < 10; i++) begin
      if (i % 3 == 2) begin
         a.raw = rand_addr();
      end else begin
         a.raw = known_addrs[next_rand() % known_addrs.size()];
         a.fields.word_sel = 2'(next_rand());
      end
      addrs.push_back(a.raw);
      predict(a.raw, hit, way, data);
      exp_q.push_back({hit, way, data});
   end
   issued  = 0;
   cycles  = 0;
   started = 1'b0;
   while (exp_q.size() > 0) begin
      req_valid = (issued < addrs.size());
      if (req_valid) begin
         req_addr = addrs[issued];
         issued++;
      end
      @(posedge clk);
      #1;
      cycles++;
      if (resp_valid) begin
         if (!started) check_value("pipeline", "first latency", 32'd2, cycles);
         started = 1'b1;
         exp = exp_q.pop_front();
         check_value("pipeline", "resp_hit", exp[34], resp_hit);
         check_value("pipeline", "resp_way", exp[33:32], resp_way);
         check_value("pipeline", "resp_data", exp[31:0], resp_data);
      end else if (started) begin
         abort_run("gap in the back to back responses of the pipeline test");
      end
      if (cycles > addrs.size() + resp_timeout) begin
         abort_run("pipeline responses did not all arrive before the timeout");
      end
   end
   req_valid = 1'b0;
endtask

// ==== bench/cache_tb.sv ====
`timescale 1ns/1ns

module cache_tb;

   localparam int resp_timeout = 20;  // cycles allowed for one response

   logic                             clk;
   logic                             reset;
   logic                             req_valid;
   logic [31:0]                      req_addr;
   logic                             refill_valid;
   logic [31:0]                      refill_addr;
   logic [cache_pkg::line_width-1:0] refill_line;
   logic                             resp_valid;
   logic                             resp_hit;
   logic [cache_pkg::way_width-1:0]  resp_way;
   logic [31:0]                      resp_data;

   // reference model of the tag and data stores
   logic [cache_pkg::tag_width-1:0]  model_tag   [cache_pkg::num_sets][cache_pkg::num_ways];
   logic                             model_valid [cache_pkg::num_sets][cache_pkg::num_ways];
   logic [cache_pkg::line_width-1:0] model_line  [cache_pkg::num_sets][cache_pkg::num_ways];
   logic [cache_pkg::way_width-1:0]  model_ptr   [cache_pkg::num_sets];  // own victim pointers
   logic [31:0]                      known_addrs [$];                    // every refilled address

   logic [31:0] lcg_state = 32'hf002;

   cache_top u_cache_top (
      .clk          (clk),
      .reset        (reset),
      .req_valid    (req_valid),
      .req_addr     (req_addr),
      .refill_valid (refill_valid),
      .refill_addr  (refill_addr),
      .refill_line  (refill_line),
      .resp_valid   (resp_valid),
      .resp_hit     (resp_hit),
      .resp_way     (resp_way),
      .resp_data    (resp_data)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;  // 4 ns period
   end

   function logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // word aligned random address
   function logic [31:0] rand_addr();
      cache_pkg::cache_addr_u a;
      a.raw = next_rand();
      a.fields.byte_sel = 2'b00;
      return a.raw;
   endfunction

   function logic [cache_pkg::line_width-1:0] rand_line();
      return {next_rand(), next_rand(), next_rand(), next_rand()};
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_value(input string test_name, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
      if (expected !== actual) begin
         abort_run($sformatf("CHECK FAILED %s %s expected %0h actual %0h",
                             test_name, field, expected, actual));
      end
   endtask

   task automatic clear_model();
      for (int s = 0; s < cache_pkg::num_sets; s++) begin
         model_ptr[s] = '0;
         for (int w = 0; w < cache_pkg::num_ways; w++) begin
            model_tag[s][w]   = '0;
            model_valid[s][w] = 1'b0;  // RAM starts at zero, all invalid
            model_line[s][w]  = '0;
         end
      end
   endtask

   // expected response for one address from the model alone
   task automatic predict(input logic [31:0] addr, output logic hit,
                          output logic [cache_pkg::way_width-1:0] way,
                          output logic [31:0] data);
      cache_pkg::cache_addr_u a;
      a.raw = addr;
      hit   = 1'b0;
      way   = '0;
      data  = '0;  // zero way and data on a miss
      for (int w = 0; w < cache_pkg::num_ways; w++) begin
         if (model_valid[a.fields.index][w] && model_tag[a.fields.index][w] == a.fields.tag) begin
            hit  = 1'b1;
            way  = w[cache_pkg::way_width-1:0];
            data = model_line[a.fields.index][w][32*a.fields.word_sel +: 32];
         end
      end
   endtask

   `include "cache_tb_tasks.svh"

   initial begin
      req_valid    = 1'b0;
      req_addr     = '0;
      refill_valid = 1'b0;
      refill_addr  = '0;
      refill_line  = '0;
      reset        = 1'b1;
      clear_model();
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      @(posedge clk);
      #1;  // every task starts and ends 1 ns after an edge
      cold_miss_reads();
      refill_then_hit();
      replacement_order();
      same_cycle_bypass();
      back_to_back_reads();
      $display("Test completed successfully");
      $finish;
   end

endmodule

// ==== compile.f ====
src/cache_pkg.sv
src/cache_way_if.sv
src/simple_port_ram.sv
src/cache_way.sv
src/lookup_ctrl.sv
src/hit_merge.sv
src/cache_top.sv
+incdir+bench
bench/cache_tb.sv

// ==== src/cache_pkg.sv ====
package cache_pkg;

   // cache geometry
   localparam int num_ways       = 4;    // ways per set
   localparam int num_sets       = 256;  // sets per way
   localparam int index_width    = 8;    // log2 of num_sets
   localparam int tag_width      = 20;   // upper address bits kept per line
   localparam int word_sel_width = 2;    // four 32-bit words per line
   localparam int line_width     = 128;  // one full line
   localparam int way_width      = 2;    // way number

   // tag entry, valid bit on top of the tag
   localparam int entry_width    = tag_width + 1;

   // one 32-bit address, seen either raw or split into its fields
   // field order from msb down: tag, index, word_sel, byte_sel
   typedef union packed {
      logic [31:0] raw;              // as it arrives on the port
      struct packed {
         logic [tag_width-1:0]      tag;       // compared against the tag RAM
         logic [index_width-1:0]    index;     // picks the set
         logic [word_sel_width-1:0] word_sel;  // picks the word in the line
         logic [1:0]                byte_sel;  // ignored, word aligned fetch
      } fields;
   } cache_addr_u;

endpackage

// ==== src/cache_top.sv ====
`timescale 1ns/1ns

// lookup core of the 4-way instruction cache
// request in, response two cycles later, refills on a separate strobe
module cache_top (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             req_valid,
   input  logic [31:0]                      req_addr,
   input  logic                             refill_valid,
   input  logic [31:0]                      refill_addr,
   input  logic [cache_pkg::line_width-1:0] refill_line,
   output logic                             resp_valid,
   output logic                             resp_hit,
   output logic [cache_pkg::way_width-1:0]  resp_way,
   output logic [31:0]                      resp_data
);

   logic                                 stage_valid;     // request, one cycle in
   logic [cache_pkg::word_sel_width-1:0] stage_word_sel;

   // one bundle per way
   cache_way_if way_bus [cache_pkg::num_ways] ();

   // feeder: address decode and victim choice
   lookup_ctrl u_lookup_ctrl (
      .clk            (clk),
      .reset          (reset),
      .req_valid      (req_valid),
      .req_addr       (req_addr),
      .refill_valid   (refill_valid),
      .refill_addr    (refill_addr),
      .refill_line    (refill_line),
      .ways           (way_bus),
      .stage_valid    (stage_valid),
      .stage_word_sel (stage_word_sel)
   );

   // way array, tag and data RAM per way
   for (genvar w = 0; w < cache_pkg::num_ways; w++) begin : g_ways
      cache_way u_cache_way (
         .clk   (clk),
         .reset (reset),
         .port  (way_bus[w])
      );
   end

   // drain: hit merge and response register
   hit_merge u_hit_merge (
      .clk            (clk),
      .reset          (reset),
      .ways           (way_bus),
      .stage_valid    (stage_valid),
      .stage_word_sel (stage_word_sel),
      .resp_valid     (resp_valid),
      .resp_hit       (resp_hit),
      .resp_way       (resp_way),
      .resp_data      (resp_data)
   );

endmodule

// ==== src/cache_way.sv ====
`timescale 1ns/1ns

// one way of the cache
// tag RAM holds {valid, tag} per set, data RAM holds the line
module cache_way (
   input  logic  clk,
   input  logic  reset,
   cache_way_if.way port
);

   logic [cache_pkg::entry_width-1:0] tag_wr_entry;  // entry as written on refill
   logic [cache_pkg::entry_width-1:0] tag_rd_entry;  // entry read for the lookup
   logic [cache_pkg::tag_width-1:0]   stored_tag;
   logic                              stored_valid;

   // a refilled entry is always valid
   assign tag_wr_entry = {1'b1, port.wr_tag};

   // tag store
   simple_port_ram #(
      .data_width (cache_pkg::entry_width),
      .size       (cache_pkg::num_sets)
   ) u_tag_ram (
      .clk   (clk),
      .reset (reset),
      .wea   (1'b1),            // word wide write, ena does the gating
      .ena   (port.wr_en),
      .enb   (port.rd_en),
      .addra (port.wr_index),
      .addrb (port.rd_index),
      .dina  (tag_wr_entry),
      .doutb (tag_rd_entry)
   );

   // line store, read in parallel with the tag
   simple_port_ram #(
      .data_width (cache_pkg::line_width),
      .size       (cache_pkg::num_sets)
   ) u_data_ram (
      .clk   (clk),
      .reset (reset),
      .wea   (1'b1),
      .ena   (port.wr_en),
      .enb   (port.rd_en),
      .addra (port.wr_index),
      .addrb (port.rd_index),
      .dina  (port.wr_line),
      .doutb (port.line)        // line goes straight to the drain
   );

   assign stored_valid = tag_rd_entry[cache_pkg::entry_width-1];  // valid on top
   assign stored_tag   = tag_rd_entry[cache_pkg::tag_width-1:0];

   // tag compare in the cycle after the read
   // cmp_tag is registered in the feeder so it lines up with the RAM output
   assign port.hit = stored_valid && (stored_tag == port.cmp_tag);

endmodule

// ==== src/cache_way_if.sv ====
`timescale 1ns/1ns

// signals between the feeder, one way and the drain
interface cache_way_if;

   // read side, driven by the feeder
   logic                                rd_en;     // read strobe
   logic [cache_pkg::index_width-1:0]   rd_index;  // set to look up
   logic [cache_pkg::tag_width-1:0]     cmp_tag;   // request tag, one cycle after rd_en

   // refill side, only the victim way sees wr_en
   logic                                wr_en;
   logic [cache_pkg::index_width-1:0]   wr_index;
   logic [cache_pkg::tag_width-1:0]     wr_tag;
   logic [cache_pkg::line_width-1:0]    wr_line;

   // results of the way
   logic                                hit;
   logic [cache_pkg::line_width-1:0]    line;

   modport feed (
      output rd_en, rd_index, cmp_tag,
      output wr_en, wr_index, wr_tag, wr_line
   );

   modport way (
      input  rd_en, rd_index, cmp_tag,
      input  wr_en, wr_index, wr_tag, wr_line,
      output hit, line
   );

   modport drain (input hit, line);

endinterface

// ==== src/hit_merge.sv ====
`timescale 1ns/1ns

// drain of the way array
// merges the way hits into one response and registers it
module hit_merge (
   input  logic                                 clk,
   input  logic                                 reset,
   cache_way_if.drain                           ways [cache_pkg::num_ways],
   input  logic                                 stage_valid,
   input  logic [cache_pkg::word_sel_width-1:0] stage_word_sel,
   output logic                                 resp_valid,
   output logic                                 resp_hit,
   output logic [cache_pkg::way_width-1:0]      resp_way,
   output logic [31:0]                          resp_data
);

   logic [cache_pkg::num_ways-1:0]   hit_vec;                        // one bit per way
   logic [cache_pkg::line_width-1:0] way_line [cache_pkg::num_ways];
   logic                             any_hit;
   logic [cache_pkg::way_width-1:0]  hit_way;
   logic [cache_pkg::line_width-1:0] sel_line;
   logic [(2**cache_pkg::word_sel_width)-1:0][31:0] sel_words;       // word 0 in the low bits

   for (genvar w = 0; w < cache_pkg::num_ways; w++) begin : g_collect
      assign hit_vec[w]  = ways[w].hit;
      assign way_line[w] = ways[w].line;
   end

   // hits are one hot, so OR-ing masked values is the mux
   // nothing hits -> way and line stay zero
   always_comb begin
      hit_way  = '0;
      sel_line = '0;
      for (int i = 0; i < cache_pkg::num_ways; i++) begin
         if (hit_vec[i]) begin
            hit_way  = hit_way | i[cache_pkg::way_width-1:0];
            sel_line = sel_line | way_line[i];
         end
      end
   end

   assign any_hit   = |hit_vec;
   assign sel_words = sel_line;

   always_ff @(posedge clk) begin
      if (reset) begin
         resp_valid <= 1'b0;
      end else begin
         resp_valid <= stage_valid;  // second cycle of the lookup
      end
   end

   // response payload holds between requests
   always_ff @(posedge clk) begin
      if (stage_valid) begin
         resp_hit  <= any_hit;
         resp_way  <= hit_way;
         resp_data <= sel_words[stage_word_sel];
      end
   end

   // a line refilled into two ways would make the merged line garbage
   a_hit_onehot : assert property (
      @(posedge clk) disable iff (reset)
      stage_valid |-> $onehot0(hit_vec)
   ) else $error("more than one way hit");

endmodule

// ==== src/lookup_ctrl.sv ====
`timescale 1ns/1ns

// feeder for the way array
// decodes request and refill addresses, picks the victim way,
// and stages the request for the drain
module lookup_ctrl (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                req_valid,
   input  logic [31:0]                         req_addr,
   input  logic                                refill_valid,
   input  logic [31:0]                         refill_addr,
   input  logic [cache_pkg::line_width-1:0]    refill_line,
   cache_way_if.feed                           ways [cache_pkg::num_ways],
   output logic                                stage_valid,
   output logic [cache_pkg::word_sel_width-1:0] stage_word_sel
);

   cache_pkg::cache_addr_u          req_a;      // request address split up
   cache_pkg::cache_addr_u          refill_a;   // refill address split up
   logic [cache_pkg::tag_width-1:0] cmp_tag_q;  // request tag for the compare stage

   // round robin victim pointer per set
   logic [cache_pkg::way_width-1:0] victim_ptr [cache_pkg::num_sets];
   logic [cache_pkg::way_width-1:0] victim;     // way the current refill goes to

   assign req_a.raw    = req_addr;
   assign refill_a.raw = refill_addr;

   assign victim = victim_ptr[refill_a.fields.index];

   // request stage, valid half
   always_ff @(posedge clk) begin
      if (reset) begin
         stage_valid <= 1'b0;
      end else begin
         stage_valid <= req_valid;
      end
   end

   // request stage, payload half
   always_ff @(posedge clk) begin
      cmp_tag_q      <= req_a.fields.tag;       // meets the RAM output next cycle
      stage_word_sel <= req_a.fields.word_sel;
   end

   // advance the pointer of the refilled set, wraps after way 3
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int s = 0; s < cache_pkg::num_sets; s++) begin
            victim_ptr[s] <= '0;
         end
      end else if (refill_valid) begin
         victim_ptr[refill_a.fields.index] <= victim + 1'b1;
      end
   end

   // every way sees the same read and the same refill data
   // only the victim gets the write strobe
   for (genvar w = 0; w < cache_pkg::num_ways; w++) begin : g_way
      assign ways[w].rd_en    = req_valid;                  // no back pressure
      assign ways[w].rd_index = req_a.fields.index;
      assign ways[w].cmp_tag  = cmp_tag_q;
      assign ways[w].wr_en    = refill_valid && (int'(victim) == w);
      assign ways[w].wr_index = refill_a.fields.index;
      assign ways[w].wr_tag   = refill_a.fields.tag;
      assign ways[w].wr_line  = refill_line;
   end

   // an unknown address would read or write an unknown set in every way
   a_req_addr_known : assert property (
      @(posedge clk) disable iff (reset)
      req_valid |-> !$isunknown(req_addr)
   ) else $error("request address has unknown bits");

   a_refill_addr_known : assert property (
      @(posedge clk) disable iff (reset)
      refill_valid |-> !$isunknown(refill_addr)
   ) else $error("refill address has unknown bits");

endmodule

// ==== src/simple_port_ram.sv ====
`timescale 1ns/1ns

// simple dual port RAM, port a writes and port b reads
// read first, one cycle of read latency, write to read bypass
module simple_port_ram #(
   parameter int data_width = 32,
   parameter int size       = 256
) (
   input  logic                    clk,
   input  logic                    reset,   // clears the output register only
   input  logic                    wea,
   input  logic                    ena,
   input  logic                    enb,
   input  logic [$clog2(size)-1:0] addra,
   input  logic [$clog2(size)-1:0] addrb,
   input  logic [data_width-1:0]   dina,
   output logic [data_width-1:0]   doutb
);

   logic [data_width-1:0] mem [size];
   logic [data_width-1:0] ram_q;         // registered read of the array
   logic [data_width-1:0] bypass_data;   // dina captured on a colliding write
   logic                  bypass_valid;  // next doutb comes from bypass_data

   // contents start at zero, so every tag entry starts invalid
   initial begin
      for (int i = 0; i < size; i++) begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (wea && ena) begin
         mem[addra] <= dina;
      end
   end

   // read first: the array alone would still give the old word
   always_ff @(posedge clk) begin
      if (reset) begin
         ram_q        <= '0;
         bypass_valid <= 1'b0;
      end else if (enb) begin
         ram_q        <= mem[addrb];
         bypass_valid <= wea && ena && (addra == addrb);  // same set written this cycle
      end
   end

   always_ff @(posedge clk) begin
      if (enb) begin
         bypass_data <= dina;
      end
   end

   assign doutb = bypass_valid ? bypass_data : ram_q;

endmodule
